// ==== decoder.f ====
rtl/dec_sym_pkg.sv
rtl/dec_reg_pkg.sv
rtl/biphase_to_nrz.sv
rtl/mrk_spc_decode.sv
rtl/symbol_demux.sv
rtl/nrz_derandomizer.sv
rtl/format_output.sv
rtl/decoder_regs.sv
rtl/decoder.sv
testbench/decoder_tb.sv

// ==== rtl/biphase_to_nrz.sv ====
/*
  Biphase to NRZ converter
  Pairs the two half-symbols of a Manchester bit into one soft decision
*/
`timescale 1ns/1ps

module biphase_to_nrz (
  input  logic               ck933,
  input  logic               rs,
  input  logic               symb_clk_en_i,
  input  logic               enable_i,
  input  dec_sym_pkg::soft_t symb_i,
  output dec_sym_pkg::soft_t nrz_o,
  output logic               bi_en_o
);
  import dec_sym_pkg::*;

  soft_t      first_half;
  soft_t      larger;
  soft_t      decision;
  soft_t      nrz_q;
  logic       phase;
  logic       sign;
  logic [1:0] strength;

  // High half first means a one
  assign sign     = first_half > symb_i;
  assign larger   = sign ? first_half : symb_i;
  // Weak result when neither half reaches the upper range
  assign strength = larger[2] ? larger[1:0] : 2'b00;
  assign decision = sign ? {1'b1, strength} : {1'b0, ~strength};

  // First half kept for pairing
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs)
      first_half <= '0;
    else if (symb_clk_en_i && !phase)
      first_half <= symb_i;
  end

  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      phase <= 1'b0;
      nrz_q <= '0;
    end else if (!enable_i) begin
      phase <= 1'b0;
    end else if (symb_clk_en_i) begin
      phase <= ~phase;
      // Decision registered on the second half
      if (phase)
        nrz_q <= decision;
    end
  end

  // Release the held decision on the next first-half strobe
  assign nrz_o   = enable_i ? nrz_q : symb_i;
  assign bi_en_o = symb_clk_en_i & (~enable_i | ~phase);

  a_release_known: assert property (@(posedge ck933) disable iff (rs)
    bi_en_o |-> !$isunknown(nrz_o))
    else $error("bi_en_o released an unknown NRZ decision");

endmodule

// ==== rtl/dec_reg_pkg.sv ====
/*
  Decoder register map
  Bus types, register addresses and the decoded mode word
*/

package dec_reg_pkg;

  // --------------------------------------------------
  // Bus types
  // --------------------------------------------------

  typedef logic [11:0] reg_addr_t;
  typedef logic [15:0] reg_data_t;

  // --------------------------------------------------
  // Address map
  // --------------------------------------------------

  // Mode word, read/write
  localparam reg_addr_t ADDR_MODE = 12'h040;
  // Identification word, read only
  localparam reg_addr_t ADDR_ID   = 12'h041;
  localparam reg_data_t ID_VALUE  = 16'hDC01;

  // Mode word fields, bit 11 down to bit 0
  // Upper four bits of the word are not stored
  typedef struct packed {
    dec_sym_pkg::decode_mode_t mode;
    logic                      sign_mag;
    logic                      biphase;
    logic                      swap;
    logic                      fqpsk;
    logic                      demux;
    logic                      derandomize;
    logic                      data_inv;
    logic                      clk_sel;
    logic                      clk_inv;
    logic                      fifo_rs;
  } dec_ctrl_t;

endpackage

// ==== rtl/dec_sym_pkg.sv ====
/*
  Decoder symbol path definitions
  Soft decision types, differential decoding modes and datapath constants
*/

package dec_sym_pkg;

  // --------------------------------------------------
  // Soft decisions
  // --------------------------------------------------

  // Offset binary, bit 2 is the hard decision
  // 3'b111 strong one, 3'b000 strong zero
  typedef logic [2:0] soft_t;

  // One I/Q pair as it moves between stages
  typedef struct packed {
    soft_t i;
    soft_t q;
  } iq_soft_t;

  // Differential decoding selection
  typedef enum logic [1:0] {
    DEC_NRZL = 2'd0,
    DEC_NRZM = 2'd1,
    DEC_NRZS = 2'd2
  } decode_mode_t;

  // --------------------------------------------------
  // Pipeline constants
  // --------------------------------------------------

  // Descrambler length, taps at the two last stages
  localparam int LFSR_LEN = 15;

  // Datapath latency in twice-rate strobes, NRZ-L without biphase
  localparam int PIPE_LAT = 4;

endpackage

// ==== rtl/decoder.sv ====
/*
  Telemetry bit decoder, top level
  Biphase, mark/space, demux, descrambler and formatting stages
  plus the data clock strobe and the control outputs
*/
`timescale 1ns/1ps

module decoder (
  input  logic                   ck933,
  input  logic                   rs,
  input  logic                   en_i,
  input  logic                   wr0_i,
  input  logic                   wr1_i,
  input  dec_reg_pkg::reg_addr_t addr_i,
  input  dec_reg_pkg::reg_data_t din_i,
  output dec_reg_pkg::reg_data_t dout_o,
  input  logic                   symb_clk_en_i,
  input  logic                   symb_clk_2x_en_i,
  input  dec_sym_pkg::soft_t     symb_i_i,
  input  dec_sym_pkg::soft_t     symb_q_i,
  output dec_sym_pkg::soft_t     soft_i_o,
  output dec_sym_pkg::soft_t     soft_q_o,
  output logic                   dout_i_o,
  output logic                   dout_q_o,
  output logic                   cout_o,
  output logic                   fifo_rs_o,
  output logic                   clk_inv_o
);
  import dec_sym_pkg::*;
  import dec_reg_pkg::*;

  dec_ctrl_t ctrl;
  soft_t     nrz_i, nrz_q, q_align, dec_i, dec_q;
  logic      bi_en;
  iq_soft_t  dec_pair, sel_pair, derand_pair;

  // --------------------------------------------------
  // Registers
  // --------------------------------------------------
  decoder_regs i_regs (.ck933, .rs, .en_i, .wr0_i, .wr1_i, .addr_i, .din_i,
    .dout_o, .ctrl_o(ctrl));

  assign fifo_rs_o = ctrl.fifo_rs;
  assign clk_inv_o = ctrl.clk_inv;

  // --------------------------------------------------
  // Biphase and mark/space
  // --------------------------------------------------
  biphase_to_nrz i_biphase (.ck933, .rs, .symb_clk_en_i, .enable_i(ctrl.biphase),
    .symb_i(symb_i_i), .nrz_o(nrz_i), .bi_en_o(bi_en));

  // Q held with the second half so it lines up with the I decision
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs)
      q_align <= '0;
    else if (symb_clk_en_i && ctrl.biphase && !bi_en)
      q_align <= symb_q_i;
  end
  assign nrz_q = ctrl.biphase ? q_align : symb_q_i;

  mrk_spc_decode i_mrk_spc_i (.ck933, .rs, .clk_en_i(symb_clk_en_i), .bi_en_i(bi_en),
    .mode_i(ctrl.mode), .din_i(nrz_i), .dout_o(dec_i));
  mrk_spc_decode i_mrk_spc_q (.ck933, .rs, .clk_en_i(symb_clk_en_i), .bi_en_i(bi_en),
    .mode_i(ctrl.mode), .din_i(nrz_q), .dout_o(dec_q));

  assign dec_pair = '{i: dec_i, q: dec_q};

  // --------------------------------------------------
  // Demux, descrambler, formatting
  // --------------------------------------------------
  symbol_demux i_demux (.ck933, .rs, .symb_clk_en_i, .symb_clk_2x_en_i, .ctrl_i(ctrl),
    .dec_i(dec_pair), .sel_o(sel_pair));

  nrz_derandomizer i_derand (.ck933, .rs, .clk_en_i(symb_clk_2x_en_i),
    .derand_i(ctrl.derandomize), .inv_i(ctrl.data_inv), .din_i(sel_pair),
    .dout_o(derand_pair));

  format_output i_format_i (.ck933, .rs, .clk_en_i(symb_clk_2x_en_i),
    .sign_mag_i(ctrl.sign_mag), .din_i(derand_pair.i), .dout_o(soft_i_o));
  format_output i_format_q (.ck933, .rs, .clk_en_i(symb_clk_2x_en_i),
    .sign_mag_i(ctrl.sign_mag), .din_i(derand_pair.q), .dout_o(soft_q_o));

  // Hard bits for the serial outputs
  assign dout_i_o = soft_i_o[2];
  assign dout_q_o = soft_q_o[2];

  // Data clock strobe, biphase rate first
  assign cout_o = ctrl.biphase ? bi_en :
                  ctrl.clk_sel ? symb_clk_en_i : symb_clk_2x_en_i;

endmodule

// ==== rtl/decoder_regs.sv ====
/*
  Decoder register bank
  Mode word with byte-lane writes, identification word, read mux
*/
`timescale 1ns/1ps

module decoder_regs (
  input  logic                   ck933,
  input  logic                   rs,
  input  logic                   en_i,
  input  logic                   wr0_i,
  input  logic                   wr1_i,
  input  dec_reg_pkg::reg_addr_t addr_i,
  input  dec_reg_pkg::reg_data_t din_i,
  output dec_reg_pkg::reg_data_t dout_o,
  output dec_reg_pkg::dec_ctrl_t ctrl_o
);
  import dec_reg_pkg::*;

  logic [$bits(dec_ctrl_t)-1:0] mode_q;
  logic                         mode_sel;

  assign mode_sel = en_i && (addr_i == ADDR_MODE);

  // Low byte on wr0, high lane on wr1
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      mode_q <= '0;
    end else if (mode_sel) begin
      if (wr0_i)
        mode_q[7:0] <= din_i[7:0];
      if (wr1_i)
        mode_q[11:8] <= din_i[11:8];
    end
  end

  assign ctrl_o = dec_ctrl_t'(mode_q);

  // Combinational read, zero when not selected
  always_comb begin
    dout_o = '0;
    if (en_i) begin
      case (addr_i)
        ADDR_MODE: dout_o = {4'h0, mode_q};
        ADDR_ID:   dout_o = ID_VALUE;
        default:   dout_o = '0;
      endcase
    end
  end

  a_wr_needs_en: assert property (@(posedge ck933) disable iff (rs)
    (wr0_i || wr1_i) |-> en_i)
    else $error("register write strobe without en_i");

endmodule

// ==== rtl/format_output.sv ====
/*
  Soft output formatter, one rail
  Offset binary or sign-magnitude
*/
`timescale 1ns/1ps

module format_output (
  input  logic               ck933,
  input  logic               rs,
  input  logic               clk_en_i,
  input  logic               sign_mag_i,
  input  dec_sym_pkg::soft_t din_i,
  output dec_sym_pkg::soft_t dout_o
);

  logic [1:0] mag;

  // Negative half counts down in offset binary
  // so the magnitude is flipped there
  assign mag = din_i[2] ? din_i[1:0] : ~din_i[1:0];

  // --------------------------------------------------
  // Output register
  // --------------------------------------------------
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      dout_o <= '0;
    end else if (clk_en_i) begin
      if (sign_mag_i)
        dout_o <= {din_i[2], mag};
      else
        dout_o <= din_i;
    end
  end

endmodule

// ==== rtl/mrk_spc_decode.sv ====
/*
  Mark/space differential decoder, one rail
  Recovers NRZ-L from NRZ-M or NRZ-S, soft magnitude kept
*/
`timescale 1ns/1ps

module mrk_spc_decode (
  input  logic                      ck933,
  input  logic                      rs,
  input  logic                      clk_en_i,
  input  logic                      bi_en_i,
  input  dec_sym_pkg::decode_mode_t mode_i,
  input  dec_sym_pkg::soft_t        din_i,
  output dec_sym_pkg::soft_t        dout_o
);
  import dec_sym_pkg::*;

  logic last_hard;
  logic hard;
  logic step;

  // Only symbols released by the biphase stage
  assign step = clk_en_i & bi_en_i;

  // --------------------------------------------------
  // Hard bit recovery
  // --------------------------------------------------
  always_comb begin
    case (mode_i)
      // Transition means one
      DEC_NRZM: hard = din_i[2] ^ last_hard;
      // No transition means one
      DEC_NRZS: hard = ~(din_i[2] ^ last_hard);
      default:  hard = din_i[2];
    endcase
  end

  // --------------------------------------------------
  // Output register
  // --------------------------------------------------
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      last_hard <= 1'b0;
      dout_o    <= '0;
    end else if (step) begin
      last_hard <= din_i[2];
      // Magnitude bits untouched
      dout_o    <= {hard, din_i[1:0]};
    end
  end

endmodule

// ==== rtl/nrz_derandomizer.sv ====
/*
  Randomized NRZ-L descrambler with data inversion
  Self-synchronizing, taps at stages 15 and 14, both rails
*/
`timescale 1ns/1ps

module nrz_derandomizer (
  input  logic                  ck933,
  input  logic                  rs,
  input  logic                  clk_en_i,
  input  logic                  derand_i,
  input  logic                  inv_i,
  input  dec_sym_pkg::iq_soft_t din_i,
  output dec_sym_pkg::iq_soft_t dout_o
);
  import dec_sym_pkg::*;

  logic [LFSR_LEN-1:0] shift_q;
  logic                descr_bit;
  soft_t               rail_i;
  soft_t               rail_q;

  // Received bit against stages 15 and 14
  assign descr_bit = din_i.i[2] ^ shift_q[LFSR_LEN-1] ^ shift_q[LFSR_LEN-2];

  // Bypass or descrambled hard bit, magnitudes kept
  always_comb begin
    rail_i = din_i.i;
    rail_q = din_i.q;
    if (derand_i) begin
      rail_i[2] = descr_bit;
      rail_q[2] = descr_bit;
    end
  end

  // --------------------------------------------------
  // Shift register and output
  // --------------------------------------------------
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      shift_q <= '0;
      dout_o  <= '0;
    end else if (clk_en_i) begin
      // Fed with received, still scrambled bits
      shift_q  <= {shift_q[LFSR_LEN-2:0], din_i.i[2]};
      dout_o.i <= inv_i ? ~rail_i : rail_i;
      dout_o.q <= inv_i ? ~rail_q : rail_q;
    end
  end

endmodule

// ==== rtl/symbol_demux.sv ====
/*
  QPSK/OQPSK and FQPSK demultiplexer
  Interleaves I and Q at twice the symbol rate, or passes the pair
*/
`timescale 1ns/1ps

module symbol_demux (
  input  logic                   ck933,
  input  logic                   rs,
  input  logic                   symb_clk_en_i,
  input  logic                   symb_clk_2x_en_i,
  input  dec_reg_pkg::dec_ctrl_t ctrl_i,
  input  dec_sym_pkg::iq_soft_t  dec_i,
  output dec_sym_pkg::iq_soft_t  sel_o
);
  import dec_sym_pkg::*;

  iq_soft_t dec_dly;
  iq_soft_t demux_nxt;
  iq_soft_t fqpsk_nxt;
  logic     i_slot;

  // I slot on the symbol strobe, Q slot when swapped
  assign i_slot = ctrl_i.swap ^ symb_clk_en_i;

  // --------------------------------------------------
  // QPSK / OQPSK
  // --------------------------------------------------
  always_comb begin
    demux_nxt.i = i_slot ? dec_i.i : dec_i.q;
    demux_nxt.q = dec_i.q;
  end

  // --------------------------------------------------
  // FQPSK
  // --------------------------------------------------

  // Previous pair at the twice rate
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs)
      dec_dly <= '0;
    else if (symb_clk_2x_en_i)
      dec_dly <= dec_i;
  end

  // Delayed I combined with Q, Q inverted on alternate halves
  always_comb begin
    fqpsk_nxt.i = i_slot ? (dec_dly.i ^ dec_i.q) : (dec_dly.i ^ ~dec_i.q);
    fqpsk_nxt.q = dec_dly.q;
  end

  // --------------------------------------------------
  // Output selection
  // --------------------------------------------------
  always_ff @(posedge ck933 or posedge rs) begin
    if (rs) begin
      sel_o <= '0;
    end else if (symb_clk_2x_en_i) begin
      // FQPSK wins over plain demux
      if (ctrl_i.fqpsk)
        sel_o <= fqpsk_nxt;
      else if (ctrl_i.demux)
        sel_o <= demux_nxt;
      else
        sel_o <= dec_i;
    end
  end

  // Symbol strobe must coincide with a twice-rate strobe,
  // else the I/Q slot order is lost
  a_strobe_align: assert property (@(posedge ck933) disable iff (rs)
    symb_clk_en_i |-> symb_clk_2x_en_i)
    else $error("symbol strobe without twice-rate strobe");

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Compile the decoder testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module decoder_tb -f decoder.f -o decoder_sim
if [ $? -ne 0 ]; then
  echo "Verilator compile failed"
  exit 1
fi

out=$(./obj_dir/decoder_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Everything OK"; then
  echo "Simulation passed"
  exit 0
fi

echo "Simulation did not pass"
exit 1

// ==== testbench/decoder_tb.sv ====
/*
  Telemetry bit decoder testbench
  Directed tests for register access, NRZ-L/M/S decoding, descrambling,
  sign-magnitude formatting, data clock selection and I/Q demux
*/
`timescale 1ns/1ps

module decoder_tb;
  import dec_sym_pkg::*;
  import dec_reg_pkg::*;

  // --------------------------------------------------
  // Run length
  // --------------------------------------------------
  localparam int STREAM_LEN  = 64;
  localparam int STREAM_RUNS = 9;
  // Pipeline refill plus a full descrambler history
  localparam int WARMUP      = LFSR_LEN + PIPE_LAT + 2;
  // Four clocks per twice-rate strobe, margin for bus access and cout checks
  localparam int CYCLE_LIMIT = STREAM_RUNS * STREAM_LEN * 4 + 1500;

  logic      ck933 = 1'b0;
  logic      rs;
  logic      en_i, wr0_i, wr1_i;
  reg_addr_t addr_i;
  reg_data_t din_i, dout_o;
  logic      symb_clk_en_i = 1'b0;
  logic      symb_clk_2x_en_i = 1'b0;
  soft_t     symb_i_i, symb_q_i, soft_i_o, soft_q_o;
  logic      dout_i_o, dout_q_o, cout_o, fifo_rs_o, clk_inv_o;

  // Reference state
  dec_ctrl_t           ctrl_m;
  integer              seed = 32676;
  int                  cycles = 0;
  int                  n_checks, soft_errs, word_errs, bit_errs;
  soft_t               drv_i, drv_q;
  logic                last_i, last_q;
  iq_soft_t            dec_m;
  // Entry 0 is the decoder register after the current strobe
  iq_soft_t            dec_dl [0:PIPE_LAT-1];
  logic                sym_dl [0:PIPE_LAT-2];
  logic [LFSR_LEN-1:0] ref_lfsr;
  logic [2:0]          strobe_cnt;

  decoder i_decoder (
    .ck933(ck933), .rs(rs), .en_i(en_i), .wr0_i(wr0_i), .wr1_i(wr1_i),
    .addr_i(addr_i), .din_i(din_i), .dout_o(dout_o),
    .symb_clk_en_i(symb_clk_en_i), .symb_clk_2x_en_i(symb_clk_2x_en_i),
    .symb_i_i(symb_i_i), .symb_q_i(symb_q_i), .soft_i_o(soft_i_o), .soft_q_o(soft_q_o),
    .dout_i_o(dout_i_o), .dout_q_o(dout_q_o), .cout_o(cout_o),
    .fifo_rs_o(fifo_rs_o), .clk_inv_o(clk_inv_o)
  );

  initial begin
    forever #4 ck933 = ~ck933;
  end

  // Twice-rate strobe every 4 clocks, symbol strobe on every other one
  always @(posedge ck933) begin
    if (rs) begin
      strobe_cnt       <= 3'd0;
      symb_clk_2x_en_i <= 1'b0;
      symb_clk_en_i    <= 1'b0;
    end else begin
      strobe_cnt       <= strobe_cnt + 3'd1;
      symb_clk_2x_en_i <= (strobe_cnt[1:0] == 2'd3);
      symb_clk_en_i    <= (strobe_cnt == 3'd7);
    end
  end

  always @(posedge ck933) begin
    cycles <= cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("Timeout: tests still running after %0d cycles", CYCLE_LIMIT);
      $display("Something failed");
      $finish;
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------
  task automatic check_soft(input soft_t got, input soft_t exp, input string what);
    n_checks++;
    if (got !== exp) begin
      soft_errs++;
      $display("MISMATCH at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_word(input reg_data_t got, input reg_data_t exp, input string what);
    n_checks++;
    if (got !== exp) begin
      word_errs++;
      $display("MISMATCH at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_bit(input logic got, input logic exp, input string what);
    n_checks++;
    if (got !== exp) begin
      bit_errs++;
      $display("MISMATCH at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  // --------------------------------------------------
  // Bus access
  // --------------------------------------------------
  task automatic bus_write(input reg_addr_t addr, input reg_data_t data,
                           input logic lo, input logic hi);
    @(posedge ck933);
    en_i   <= 1'b1;
    addr_i <= addr;
    din_i  <= data;
    wr0_i  <= lo;
    wr1_i  <= hi;
    @(posedge ck933);
    en_i  <= 1'b0;
    wr0_i <= 1'b0;
    wr1_i <= 1'b0;
  endtask

  task automatic bus_read(input reg_addr_t addr, output reg_data_t data);
    @(posedge ck933);
    en_i   <= 1'b1;
    addr_i <= addr;
    @(negedge ck933);
    data = dout_o;
    @(posedge ck933);
    en_i <= 1'b0;
  endtask

  task automatic set_mode(input dec_ctrl_t ctrl);
    bus_write(ADDR_MODE, {4'h0, ctrl}, 1'b1, 1'b1);
    ctrl_m = ctrl;
  endtask

  // --------------------------------------------------
  // Reference rules
  // --------------------------------------------------
  function automatic soft_t diff_decode(input decode_mode_t mode, input soft_t cur,
                                        input logic last);
    logic hard;
    case (mode)
      DEC_NRZM: hard = cur[2] ^ last;
      DEC_NRZS: hard = ~(cur[2] ^ last);
      default:  hard = cur[2];
    endcase
    return {hard, cur[1:0]};
  endfunction

  // Sign kept, magnitude flipped on the negative half
  function automatic soft_t to_sign_mag(input soft_t v);
    soft_t r;
    r = v;
    if (!v[2])
      r[1:0] = ~v[1:0];
    return r;
  endfunction

  // Edge at which the DUT takes a twice-rate strobe
  task automatic wait_2x(output logic sym);
    @(posedge ck933);
    while (!symb_clk_2x_en_i)
      @(posedge ck933);
    sym = symb_clk_en_i;
  endtask

  // Random or ramp symbols, soft outputs checked once the pipeline is refilled
  task automatic run_stream(input logic ramp, input string what);
    int          n;
    int          k;
    int          sym_cnt;
    logic        sym;
    logic        descr;
    logic [31:0] rnd;
    iq_soft_t    aligned;
    soft_t       exp_i, exp_q;
    sym_cnt = 0;
    for (n = 0; n < STREAM_LEN; n++) begin
      wait_2x(sym);
      if (sym) begin
        dec_m.i = diff_decode(ctrl_m.mode, drv_i, last_i);
        dec_m.q = diff_decode(ctrl_m.mode, drv_q, last_q);
        last_i  = drv_i[2];
        last_q  = drv_q[2];
        rnd     = $random(seed);
        drv_i   = ramp ? sym_cnt[2:0] : rnd[2:0];
        drv_q   = ramp ? ~sym_cnt[2:0] : rnd[5:3];
        symb_i_i <= drv_i;
        symb_q_i <= drv_q;
        sym_cnt++;
      end
      for (k = PIPE_LAT - 1; k > 0; k--)
        dec_dl[k] = dec_dl[k-1];
      dec_dl[0] = dec_m;
      for (k = PIPE_LAT - 2; k > 0; k--)
        sym_dl[k] = sym_dl[k-1];
      sym_dl[0] = sym;
      aligned = dec_dl[PIPE_LAT-1];
      // Demux slot taken at the demux register strobe
      if (ctrl_m.demux && !(sym_dl[PIPE_LAT-2] ^ ctrl_m.swap))
        aligned.i = dec_dl[PIPE_LAT-1].q;
      descr    = aligned.i[2] ^ ref_lfsr[LFSR_LEN-1] ^ ref_lfsr[LFSR_LEN-2];
      ref_lfsr = {ref_lfsr[LFSR_LEN-2:0], aligned.i[2]};
      exp_i    = aligned.i;
      exp_q    = aligned.q;
      if (ctrl_m.derandomize) begin
        exp_i[2] = descr;
        exp_q[2] = descr;
      end
      if (ctrl_m.data_inv) begin
        exp_i = ~exp_i;
        exp_q = ~exp_q;
      end
      if (ctrl_m.sign_mag) begin
        exp_i = to_sign_mag(exp_i);
        exp_q = to_sign_mag(exp_q);
      end
      @(negedge ck933);
      if (n >= WARMUP) begin
        check_soft(soft_i_o, exp_i, {what, " soft_i_o"});
        check_soft(soft_q_o, exp_q, {what, " soft_q_o"});
        check_bit(dout_i_o, exp_i[2], {what, " dout_i_o"});
        check_bit(dout_q_o, exp_q[2], {what, " dout_q_o"});
      end
    end
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic registers_access();
    reg_data_t rd;
    bus_read(ADDR_MODE, rd);
    check_word(rd, 16'h0000, "mode after reset");
    bus_read(ADDR_ID, rd);
    check_word(rd, ID_VALUE, "id word");
    check_bit(fifo_rs_o, 1'b0, "fifo_rs_o after reset");
    check_bit(clk_inv_o, 1'b0, "clk_inv_o after reset");
    // Low lane only, high byte of the data ignored
    bus_write(ADDR_MODE, 16'hFF03, 1'b1, 1'b0);
    bus_read(ADDR_MODE, rd);
    check_word(rd, 16'h0003, "mode low lane");
    check_bit(fifo_rs_o, 1'b1, "fifo_rs_o set");
    check_bit(clk_inv_o, 1'b1, "clk_inv_o set");
    // High lane only, top nibble not stored
    bus_write(ADDR_MODE, 16'hF5AA, 1'b0, 1'b1);
    bus_read(ADDR_MODE, rd);
    check_word(rd, 16'h0503, "mode high lane");
    bus_write(ADDR_MODE, 16'h00FE, 1'b1, 1'b0);
    bus_read(ADDR_MODE, rd);
    check_word(rd, 16'h05FE, "mode low lane rewrite");
    check_bit(fifo_rs_o, 1'b0, "fifo_rs_o cleared");
    check_bit(clk_inv_o, 1'b1, "clk_inv_o kept");
    @(negedge ck933);
    check_word(dout_o, 16'h0000, "dout_o with en_i low");
  endtask

  task automatic nrzl_inversion();
    dec_ctrl_t c;
    c = '0;
    set_mode(c);
    run_stream(1'b0, "NRZ-L");
    c.data_inv = 1'b1;
    set_mode(c);
    run_stream(1'b0, "NRZ-L inverted");
  endtask

  task automatic mark_space_decoding();
    dec_ctrl_t c;
    c = '0;
    c.mode = DEC_NRZM;
    set_mode(c);
    run_stream(1'b0, "NRZ-M");
    c.mode = DEC_NRZS;
    set_mode(c);
    run_stream(1'b0, "NRZ-S");
  endtask

  task automatic derandomizing();
    dec_ctrl_t c;
    c = '0;
    c.derandomize = 1'b1;
    set_mode(c);
    run_stream(1'b0, "derandomize");
    c.data_inv = 1'b1;
    set_mode(c);
    run_stream(1'b0, "derandomize inverted");
  endtask

  task automatic sign_mag_format();
    dec_ctrl_t c;
    c = '0;
    c.sign_mag = 1'b1;
    set_mode(c);
    // Ramp so every soft value reaches the formatter
    run_stream(1'b1, "sign-magnitude");
  endtask

  task automatic clock_and_demux();
    dec_ctrl_t c;
    int        k;
    c = '0;
    set_mode(c);
    for (k = 0; k < 32; k++) begin
      @(negedge ck933);
      check_bit(cout_o, symb_clk_2x_en_i, "cout_o twice rate");
    end
    c.clk_sel = 1'b1;
    set_mode(c);
    for (k = 0; k < 32; k++) begin
      @(negedge ck933);
      check_bit(cout_o, symb_clk_en_i, "cout_o symbol rate");
    end
    c.demux = 1'b1;
    set_mode(c);
    run_stream(1'b0, "demux");
    c.swap = 1'b1;
    set_mode(c);
    run_stream(1'b0, "demux swapped");
  endtask

  initial begin
    rs        = 1'b1;
    en_i      = 1'b0;
    wr0_i     = 1'b0;
    wr1_i     = 1'b0;
    addr_i    = '0;
    din_i     = '0;
    symb_i_i  = '0;
    symb_q_i  = '0;
    drv_i     = '0;
    drv_q     = '0;
    last_i    = 1'b0;
    last_q    = 1'b0;
    dec_m     = '0;
    ref_lfsr  = '0;
    ctrl_m    = '0;
    n_checks  = 0;
    soft_errs = 0;
    word_errs = 0;
    bit_errs  = 0;
    for (int k = 0; k < PIPE_LAT; k++)
      dec_dl[k] = '0;
    for (int k = 0; k < PIPE_LAT - 1; k++)
      sym_dl[k] = 1'b0;
    repeat (2) @(posedge ck933);
    rs <= 1'b0;
    registers_access();
    nrzl_inversion();
    mark_space_decoding();
    derandomizing();
    sign_mag_format();
    clock_and_demux();
    $display("Checks %0d, soft errors %0d, word errors %0d, bit errors %0d",
             n_checks, soft_errs, word_errs, bit_errs);
    if (soft_errs + word_errs + bit_errs == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
